// File: tb/heap_vectors.txt
# columns, all hex: op prio payload exp_min_valid exp_min_prio exp_min_payload exp_free_slots
# op 1 is enq, 2 is deq_min, 3 is replace; min_prio and min_payload are ignored when valid is 0
1 0500 a001 1 0500 a001 e
1 0300 a002 1 0300 a002 d
1 0800 a003 1 0300 a002 c
1 0100 a004 1 0100 a004 b
1 0900 a005 1 0100 a004 a
1 0200 a006 1 0100 a004 9
1 0700 a007 1 0100 a004 8
1 0050 a008 1 0050 a008 7
1 0600 a009 1 0050 a008 6
1 0a00 a00a 1 0050 a008 5
1 0400 a00b 1 0050 a008 4
1 0c00 a00c 1 0050 a008 3
1 0020 a00d 1 0020 a00d 2
1 0b00 a00e 1 0020 a00d 1
1 0d00 a00f 1 0020 a00d 0
2 0000 0000 1 0050 a008 1
1 0030 a010 1 0030 a010 0
2 0000 0000 1 0050 a008 1
2 0000 0000 1 0100 a004 2
3 0450 a011 1 0200 a006 2
3 0010 a012 1 0010 a012 2
3 0e00 a013 1 0300 a002 2
2 0000 0000 1 0400 a00b 3
2 0000 0000 1 0450 a011 4
2 0000 0000 1 0500 a001 5
2 0000 0000 1 0600 a009 6
2 0000 0000 1 0700 a007 7
2 0000 0000 1 0800 a003 8
2 0000 0000 1 0900 a005 9
2 0000 0000 1 0a00 a00a a
2 0000 0000 1 0b00 a00e b
2 0000 0000 1 0c00 a00c c
2 0000 0000 1 0d00 a00f d
2 0000 0000 1 0e00 a013 e
2 0000 0000 0 0000 0000 f

// File: vlog.f
design/heap_pkg.sv
design/heap_entry_if.sv
design/heap_root.sv
design/sift_stage.sv
design/level_mem.sv
design/heap_queue.sv
tb/heap_queue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   --top-module heap_queue_tb -f vlog.f -o heap_queue_sim

./obj_dir/heap_queue_sim 2>&1 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: tb/heap_queue_tb.sv
// Testbench for the pipelined heap queue.
// Runs the operations listed in tb/heap_vectors.txt and checks the min outputs
// and free_slots after each one, then issues a pseudo-random mix of enq,
// deq_min and replace checked against a sorted reference list.

`timescale 1ns/100ps

module heap_queue_tb import heap_pkg::*; ();

   localparam int reset_cycles  = 4;
   localparam int burst_ops     = 60;
   localparam int max_vectors   = 64;
   localparam int cycles_per_op = 10;

   logic      clk = 1'b0;
   logic      rstn;
   heap_op_t  op;
   prio_t     in_prio;
   payload_t  in_payload;
   logic      ready;
   logic      min_valid;
   prio_t     min_prio;
   payload_t  min_payload;
   free_cnt_t free_slots;

   logic [1:0] vec_op     [max_vectors];
   prio_t      vec_prio   [max_vectors];
   payload_t   vec_pl     [max_vectors];
   logic       vec_valid  [max_vectors];
   prio_t      vec_min    [max_vectors];
   payload_t   vec_min_pl [max_vectors];
   free_cnt_t  vec_free   [max_vectors];
   int         num_vectors    = 0;
   logic       vectors_loaded = 1'b0;

   // reference contents, kept sorted with the smallest priority first
   prio_t    ref_prio [heap_slots];
   payload_t ref_pay  [heap_slots];
   int       ref_count = 0;

   logic [31:0] lcg_state = 32'h20c3e077;

   heap_queue uut (
      .clk(clk), .rstn(rstn),
      .op(op), .in_prio(in_prio), .in_payload(in_payload),
      .ready(ready), .min_valid(min_valid), .min_prio(min_prio),
      .min_payload(min_payload), .free_slots(free_slots)
   );

   always #2 clk = ~clk;   // 4 ns period

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_valid(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %0b, actual %0b", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_prio(input string name, input prio_t expected, input prio_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_payload(input string name, input payload_t expected,
                                input payload_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_free(input string name, input free_cnt_t expected,
                             input free_cnt_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
         abort_run();
      end
   endtask

   // min_prio and min_payload mean nothing while the heap is empty
   task automatic check_outputs(input string tag, input logic ev, input prio_t ep,
                                input payload_t epl, input free_cnt_t ef);
      check_valid({tag, " min_valid"}, ev, min_valid);
      if (ev) begin
         check_prio({tag, " min_prio"}, ep, min_prio);
         check_payload({tag, " min_payload"}, epl, min_payload);
      end
      check_free({tag, " free_slots"}, ef, free_slots);
   endtask

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic in_model(input prio_t p);
      for (int i = 0; i < ref_count; i++) begin
         if (ref_prio[i] == p) return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic model_insert(input prio_t p, input payload_t pl);
      int pos;
      pos = ref_count;
      while (pos > 0 && ref_prio[pos-1] > p) begin   // shift larger entries up
         ref_prio[pos] = ref_prio[pos-1];
         ref_pay[pos]  = ref_pay[pos-1];
         pos--;
      end
      ref_prio[pos] = p;
      ref_pay[pos]  = pl;
      ref_count++;
   endtask

   task automatic model_pop();
      for (int i = 0; i < ref_count - 1; i++) begin
         ref_prio[i] = ref_prio[i+1];
         ref_pay[i]  = ref_pay[i+1];
      end
      ref_count--;
   endtask

   task automatic apply_to_model(input heap_op_t o, input prio_t p, input payload_t pl);
      case (o)
         enq:     model_insert(p, pl);
         deq_min: model_pop();
         replace: begin
            model_pop();
            model_insert(p, pl);
         end
         default: begin
         end
      endcase
   endtask

   task automatic load_vectors();
      int          fd;
      int          n;
      string       line;
      logic [31:0] c_op, c_prio, c_pl, c_valid, c_min, c_min_pl, c_free;
      fd = $fopen("tb/heap_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file tb/heap_vectors.txt");
         abort_run();
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        c_op, c_prio, c_pl, c_valid, c_min, c_min_pl, c_free);
            if (n != 7 || num_vectors == max_vectors) begin
               $display("malformed or surplus line in the vector file: %s", line);
               abort_run();
            end else begin
               vec_op[num_vectors]     = c_op[1:0];
               vec_prio[num_vectors]   = c_prio[15:0];
               vec_pl[num_vectors]     = c_pl[15:0];
               vec_valid[num_vectors]  = c_valid[0];
               vec_min[num_vectors]    = c_min[15:0];
               vec_min_pl[num_vectors] = c_min_pl[15:0];
               vec_free[num_vectors]   = c_free[3:0];
               num_vectors++;
            end
         end
      end
      $fclose(fd);
      if (num_vectors == 0) begin
         $display("the vector file holds no usable lines");
         abort_run();
      end
   endtask

   task automatic wait_ready();
      @(negedge clk);
      while (ready !== 1'b1) @(negedge clk);
   endtask

   // entered at a falling edge with ready high, returns once ready is back
   task automatic issue_op(input heap_op_t o, input prio_t p, input payload_t pl);
      @(posedge clk);
      op         <= o;
      in_prio    <= p;
      in_payload <= pl;
      @(posedge clk);   // the DUT takes the op here
      op <= nop;
      wait_ready();
   endtask

   // ops issue back to back at every other edge
   // results of an op are checked while the next op waits at the inputs
   task automatic run_burst();
      logic [31:0] r;
      heap_op_t    o;
      prio_t       p;
      payload_t    pl;
      string       tag;
      @(posedge clk);
      for (int i = 0; i <= burst_ops; i++) begin
         if (i < burst_ops) begin
            r = next_rand();
            if (ref_count == 0) begin
               o = enq;
            end else if (ref_count == heap_slots) begin
               o = r[16] ? deq_min : replace;
            end else begin
               case (r[17:16])
                  2'd2:    o = deq_min;
                  2'd3:    o = replace;
                  default: o = enq;
               endcase
            end
            do begin
               r = next_rand();
               p = r[31:16];
            end while (in_model(p));   // keep the minimum unique
            r  = next_rand();
            pl = r[31:16];
            op         <= o;
            in_prio    <= p;
            in_payload <= pl;
         end
         @(negedge clk);
         check_valid($sformatf("burst %0d ready", i), 1'b1, ready);
         if (i > 0) begin
            check_outputs(tag, ref_count != 0, ref_prio[0], ref_pay[0],
                          free_cnt_t'(heap_slots - ref_count));
         end
         if (i < burst_ops) begin
            tag = $sformatf("burst %0d %s", i, o.name());
            apply_to_model(o, p, pl);
            @(posedge clk);   // the DUT takes the op here
            op <= nop;
            @(negedge clk);
            check_valid({tag, " ready"}, 1'b0, ready);   // busy for one cycle
            @(posedge clk);
         end
      end
   endtask

   initial begin
      int limit;
      wait (vectors_loaded);
      limit = (num_vectors + burst_ops) * cycles_per_op + reset_cycles;
      repeat (limit) @(posedge clk);
      $display("timeout: the operations did not complete within %0d cycles", limit);
      abort_run();
   end

   initial begin
      rstn       <= 1'b0;
      op         <= nop;
      in_prio    <= '0;
      in_payload <= '0;
      load_vectors();
      vectors_loaded = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_valid("reset ready", 1'b1, ready);
      check_valid("reset min_valid", 1'b0, min_valid);
      check_free("reset free_slots", free_cnt_t'(heap_slots), free_slots);

      for (int i = 0; i < num_vectors; i++) begin
         apply_to_model(heap_op_t'(vec_op[i]), vec_prio[i], vec_pl[i]);
         issue_op(heap_op_t'(vec_op[i]), vec_prio[i], vec_pl[i]);
         check_outputs($sformatf("vector %0d", i), vec_valid[i], vec_min[i],
                       vec_min_pl[i], vec_free[i]);
      end

      run_burst();

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: design/heap_queue.sv
// Pipelined min-priority queue, a binary heap with one sift stage per level.
// Present an op while ready is high. The min outputs and free_slots are final
// the next time ready is high. Several ops may still be sifting deeper down.

`timescale 1ns/100ps

module heap_queue import heap_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  heap_op_t  op,
   input  prio_t     in_prio,
   input  payload_t  in_payload,
   output logic      ready,
   output logic      min_valid,
   output prio_t     min_prio,
   output payload_t  min_payload,
   output free_cnt_t free_slots
);

   // element num_levels is the unused output of the last stage
   heap_op_t   pipe_op      [0:num_levels];
   node_addr_t pipe_addr    [0:num_levels];
   prio_t      pipe_prio    [0:num_levels];
   payload_t   pipe_payload [0:num_levels];

   heap_op_t   stage_op     [0:num_levels-1];
   node_addr_t cur_waddr    [0:num_levels-1];
   node_addr_t child_waddr  [0:num_levels-1];
   logic       cur_wen      [0:num_levels-1];
   logic       child_wen    [0:num_levels-1];

   heap_entry_if node_if     [0:num_levels-1] ();
   heap_entry_if left_if     [0:num_levels-1] ();
   heap_entry_if right_if    [0:num_levels-1] ();
   heap_entry_if cur_wr_if   [0:num_levels-1] ();
   heap_entry_if child_wr_if [0:num_levels-1] ();
   heap_entry_if top_if ();

   assign pipe_op[0]      = op;
   assign pipe_addr[0]    = node_addr_t'(1);
   assign pipe_prio[0]    = in_prio;
   assign pipe_payload[0] = in_payload;

   // leaves have no children
   assign left_if[num_levels-1].active   = 1'b0;
   assign left_if[num_levels-1].free     = '0;
   assign left_if[num_levels-1].prio     = '0;
   assign left_if[num_levels-1].payload  = '0;
   assign right_if[num_levels-1].active  = 1'b0;
   assign right_if[num_levels-1].free    = '0;
   assign right_if[num_levels-1].prio    = '0;
   assign right_if[num_levels-1].payload = '0;

   assign ready       = (stage_op[0] == nop);
   assign min_valid   = top_if.active;
   assign min_prio    = top_if.prio;
   assign min_payload = top_if.payload;
   assign free_slots  = top_if.free;

   heap_root u_root (
      .clk(clk), .rstn(rstn),
      .in_op(op), .in_prio(in_prio), .in_payload(in_payload),
      .stage_op(stage_op[0]),
      .rd_stage(node_if[0]), .rd_top(top_if),
      .wr_stage(cur_wr_if[0]), .wr_stage_en(cur_wen[0])
   );

   for (genvar s = 0; s < num_levels; s++) begin : g_stage
      sift_stage #(.level(s)) u_stage (
         .clk(clk), .rstn(rstn),
         .in_op(pipe_op[s]), .in_addr(pipe_addr[s]),
         .in_prio(pipe_prio[s]), .in_payload(pipe_payload[s]),
         .out_op(pipe_op[s+1]), .out_addr(pipe_addr[s+1]),
         .out_prio(pipe_prio[s+1]), .out_payload(pipe_payload[s+1]),
         .node(node_if[s]), .left(left_if[s]), .right(right_if[s]),
         .cur_wr(cur_wr_if[s]), .cur_waddr(cur_waddr[s]), .cur_wen(cur_wen[s]),
         .child_wr(child_wr_if[s]), .child_waddr(child_waddr[s]), .child_wen(child_wen[s]),
         .stage_op(stage_op[s])
      );
   end

   for (genvar l = 1; l < num_levels; l++) begin : g_mem
      level_mem #(.level(l)) u_mem (
         .clk(clk), .rstn(rstn),
         .op_prev(pipe_op[l-1]), .op_cur(pipe_op[l]), .op_run(stage_op[l]),
         .raddr_prev({pipe_addr[l-1][num_levels-2:0], 1'b0}),   // left child of the node above
         .raddr_cur(pipe_addr[l]),
         .waddr_prev(child_waddr[l-1]), .waddr_cur(cur_waddr[l]),
         .wr_prev(child_wr_if[l-1]), .wr_cur(cur_wr_if[l]),
         .wen_prev(child_wen[l-1]), .wen_cur(cur_wen[l]),
         .child_left(left_if[l-1]), .child_right(right_if[l-1]),
         .node(node_if[l])
      );
   end

endmodule

// File: design/level_mem.sv
// Storage for one tree level below the root, split into an even and an odd bank
// so that both children of a node come out in one read.
// Reads serve the level's own stage or, one cycle ahead, the stage above as
// child data. Writes come from the own stage or as child writes from above.
// Read latency is one cycle.

`timescale 1ns/100ps

module level_mem import heap_pkg::*; #(
   parameter int level = 1
) (
   input  logic       clk,
   input  logic       rstn,
   input  heap_op_t   op_prev,      // op entering the stage above
   input  heap_op_t   op_cur,       // op entering this level's stage
   input  heap_op_t   op_run,       // op running in this level's stage
   input  node_addr_t raddr_prev,
   input  node_addr_t raddr_cur,
   input  node_addr_t waddr_prev,
   input  node_addr_t waddr_cur,
   heap_entry_if.dst  wr_prev,
   heap_entry_if.dst  wr_cur,
   input  logic       wen_prev,
   input  logic       wen_cur,
   heap_entry_if.src  child_left,
   heap_entry_if.src  child_right,
   heap_entry_if.src  node
);

   localparam int depth = 1 << (level - 1);              // words per bank
   localparam int idx_w = (level > 1) ? level - 1 : 1;
   localparam free_cnt_t subtree_free = free_cnt_t'((1 << (num_levels - level)) - 1);

   entry_vec_t       bank_even [depth];
   entry_vec_t       bank_odd  [depth];
   entry_vec_t       wdata;
   entry_vec_t       even_q;
   entry_vec_t       odd_q;
   node_addr_t       raddr;
   node_addr_t       waddr;
   logic [idx_w-1:0] ridx;
   logic [idx_w-1:0] widx;
   logic             ren;
   logic             wen;
   logic             wen_even;
   logic             wen_odd;
   logic             rsel_odd;

   // at most one side is busy in a cycle
   assign raddr = (op_cur != nop) ? raddr_cur : raddr_prev;
   assign ren   = (op_cur != nop) || (op_prev != nop);
   assign waddr = (op_run != nop) ? waddr_cur : waddr_prev;
   assign wen   = (op_run != nop) ? wen_cur : wen_prev;
   assign wdata = (op_run != nop) ?
                  {wr_cur.active, wr_cur.free, wr_cur.prio, wr_cur.payload} :
                  {wr_prev.active, wr_prev.free, wr_prev.prio, wr_prev.payload};

   // sibling pair index within the level
   assign ridx = idx_w'((raddr >> 1) - depth);
   assign widx = idx_w'((waddr >> 1) - depth);

   assign wen_even = wen && !waddr[0];
   assign wen_odd  = wen && waddr[0];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < depth; i++) begin
            bank_even[i] <= {1'b0, subtree_free, prio_t'(0), payload_t'(0)};
            bank_odd[i]  <= {1'b0, subtree_free, prio_t'(0), payload_t'(0)};
         end
      end else begin
         if (wen_even) begin
            bank_even[widx] <= wdata;
         end
         if (wen_odd) begin
            bank_odd[widx] <= wdata;
         end
      end
   end

   // same-cycle write to the word being read is forwarded
   always_ff @(posedge clk) begin
      if (ren) begin
         even_q <= (wen_even && widx == ridx) ? wdata : bank_even[ridx];
         odd_q  <= (wen_odd && widx == ridx) ? wdata : bank_odd[ridx];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsel_odd <= 1'b0;
      end else if (ren) begin
         rsel_odd <= raddr[0];
      end
   end

   assign {child_left.active, child_left.free, child_left.prio, child_left.payload} = even_q;
   assign {child_right.active, child_right.free, child_right.prio, child_right.payload} = odd_q;
   assign {node.active, node.free, node.prio, node.payload} = rsel_odd ? odd_q : even_q;

endmodule

// File: design/sift_stage.sv
// One level of the sift pipeline.
// The incoming op is registered, then the stage compares the carried entry
// with the node at its address and with both children of that node.
// It writes the node back, may write one child, and hands the op to the next
// level or ends it by passing nop.

`timescale 1ns/100ps

module sift_stage import heap_pkg::*; #(
   parameter int level = 0
) (
   input  logic       clk,
   input  logic       rstn,
   input  heap_op_t   in_op,
   input  node_addr_t in_addr,
   input  prio_t      in_prio,
   input  payload_t   in_payload,
   output heap_op_t   out_op,
   output node_addr_t out_addr,
   output prio_t      out_prio,
   output payload_t   out_payload,
   heap_entry_if.dst  node,
   heap_entry_if.dst  left,
   heap_entry_if.dst  right,
   heap_entry_if.src  cur_wr,
   output node_addr_t cur_waddr,
   output logic       cur_wen,
   heap_entry_if.src  child_wr,
   output node_addr_t child_waddr,
   output logic       child_wen,
   output heap_op_t   stage_op
);

   heap_op_t   cur_op;
   node_addr_t cur_addr;
   prio_t      cur_prio;
   payload_t   cur_payload;

   node_addr_t left_addr;
   node_addr_t right_addr;
   logic       any_child;
   logic       go_left;
   node_addr_t pick_addr;
   free_cnt_t  pick_free;
   prio_t      pick_prio;
   payload_t   pick_payload;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_op <= nop;
      end else begin
         cur_op <= in_op;
      end
   end

   always_ff @(posedge clk) begin
      cur_addr    <= in_addr;
      cur_prio    <= in_prio;
      cur_payload <= in_payload;
   end

   assign stage_op  = cur_op;
   assign cur_waddr = cur_addr;

   assign left_addr  = {cur_addr[num_levels-2:0], 1'b0};
   assign right_addr = {cur_addr[num_levels-2:0], 1'b1};

   // smaller active child, left wins a tie
   assign any_child    = left.active || right.active;
   assign go_left      = left.active && (!right.active || left.prio <= right.prio);
   assign pick_addr    = go_left ? left_addr : right_addr;
   assign pick_free    = go_left ? left.free : right.free;
   assign pick_prio    = go_left ? left.prio : right.prio;
   assign pick_payload = go_left ? left.payload : right.payload;
   assign child_waddr  = pick_addr;

   always_comb begin
      out_op      = cur_op;
      out_addr    = left_addr;
      out_prio    = cur_prio;
      out_payload = cur_payload;

      cur_wen        = 1'b0;
      cur_wr.active  = node.active;
      cur_wr.free    = node.free;
      cur_wr.prio    = node.prio;
      cur_wr.payload = node.payload;

      child_wen        = 1'b0;
      child_wr.active  = 1'b0;
      child_wr.free    = pick_free;
      child_wr.prio    = pick_prio;
      child_wr.payload = pick_payload;

      case (cur_op)
         enq: begin
            cur_wen       = 1'b1;
            cur_wr.active = 1'b1;
            cur_wr.free   = node.free - free_cnt_t'(1);   // one more entry below
            out_addr      = (left.free != '0) ? left_addr : right_addr;
            if (!node.active) begin
               cur_wr.prio    = cur_prio;                // empty slot, sift ends here
               cur_wr.payload = cur_payload;
               out_op         = nop;
            end else if (cur_prio < node.prio) begin
               cur_wr.prio    = cur_prio;                // new entry stays, resident moves on
               cur_wr.payload = cur_payload;
               out_prio       = node.prio;
               out_payload    = node.payload;
            end
         end
         deq_min: begin
            if (!any_child) begin
               out_op = nop;
            end else begin
               cur_wen          = 1'b1;
               cur_wr.active    = 1'b1;
               cur_wr.prio      = pick_prio;
               cur_wr.payload   = pick_payload;
               child_wen        = 1'b1;                  // child is now the hole
               child_wr.free    = pick_free + free_cnt_t'(1);
               out_addr         = pick_addr;
            end
         end
         replace: begin
            if (!any_child || node.prio <= pick_prio) begin
               out_op = nop;                             // heap order already holds
            end else begin
               cur_wen          = 1'b1;
               cur_wr.prio      = pick_prio;
               cur_wr.payload   = pick_payload;
               child_wen        = 1'b1;
               child_wr.active  = 1'b1;
               child_wr.prio    = node.prio;
               child_wr.payload = node.payload;
               out_addr         = pick_addr;
            end
         end
         default: begin
         end
      endcase

      // nothing below the last level
      if (level == num_levels - 1) begin
         out_op = nop;
      end
   end

endmodule

// File: design/heap_root.sv
// Root register of the heap, level 0 of the tree.
// deq_min and replace from the input change the root at the accepting edge.
// Otherwise the root takes the write of sift stage 0 while that stage is busy.
// The register is read both by stage 0 and by the top-level min outputs.

`timescale 1ns/100ps

module heap_root import heap_pkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  heap_op_t in_op,
   input  prio_t    in_prio,
   input  payload_t in_payload,
   input  heap_op_t stage_op,     // op running in stage 0
   heap_entry_if.src rd_stage,
   heap_entry_if.src rd_top,
   heap_entry_if.dst wr_stage,
   input  logic     wr_stage_en
);

   logic      root_active;
   free_cnt_t root_free;
   prio_t     root_prio;
   payload_t  root_payload;
   logic      take_stage;

   // input-side ops and stage 0 never overlap, ops come at most every other cycle
   assign take_stage = (in_op != replace) && (in_op != deq_min) &&
                       (stage_op != nop) && wr_stage_en;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         root_active <= 1'b0;
         root_free   <= free_cnt_t'(heap_slots);
      end else if (in_op == replace) begin
         root_active <= 1'b1;                    // free count is unchanged
      end else if (in_op == deq_min) begin
         root_active <= 1'b0;                    // vacated, stage 0 pulls up a child
         root_free   <= root_free + free_cnt_t'(1);
      end else if (take_stage) begin
         root_active <= wr_stage.active;
         root_free   <= wr_stage.free;
      end
   end

   always_ff @(posedge clk) begin
      if (in_op == replace) begin
         root_prio    <= in_prio;
         root_payload <= in_payload;
      end else if (take_stage) begin
         root_prio    <= wr_stage.prio;
         root_payload <= wr_stage.payload;
      end
   end

   assign rd_stage.active  = root_active;
   assign rd_stage.free    = root_free;
   assign rd_stage.prio    = root_prio;
   assign rd_stage.payload = root_payload;

   assign rd_top.active  = root_active;
   assign rd_top.free    = root_free;
   assign rd_top.prio    = root_prio;
   assign rd_top.payload = root_payload;

endmodule

// File: design/heap_entry_if.sv
// One heap entry as it moves between a sift stage and a level memory.
// src drives the entry, dst reads it.

`timescale 1ns/100ps

interface heap_entry_if import heap_pkg::*;;

   logic      active;    // slot holds a live entry
   free_cnt_t free;      // free slots in the subtree below and including this node
   prio_t     prio;
   payload_t  payload;

   modport src (
      output active, free, prio, payload
   );

   modport dst (
      input active, free, prio, payload
   );

endinterface

// File: design/heap_pkg.sv
// Shared sizes, vector types and the operation code of the pipelined heap queue.
// Every design module imports this package in its header.
// The heap has one pipeline stage per tree level, the root being level 0.

package heap_pkg;

   localparam int num_levels    = 4;                       // tree levels and sift stages
   localparam int heap_slots    = (1 << num_levels) - 1;   // 15 entries
   localparam int prio_width    = 16;
   localparam int payload_width = 16;

   // active bit, free count, priority and payload packed into one memory word
   localparam int entry_width = 1 + num_levels + prio_width + payload_width;

   // smaller value is served first
   typedef logic [prio_width-1:0] prio_t;

   typedef logic [payload_width-1:0] payload_t;

   // free slots in a subtree, the root holds up to heap_slots
   typedef logic [num_levels-1:0] free_cnt_t;

   // heap numbering: root is 1, children of n are 2n and 2n+1
   typedef logic [num_levels-1:0] node_addr_t;

   typedef logic [entry_width-1:0] entry_vec_t;

   typedef enum logic [1:0] {
      nop     = 2'd0,
      enq     = 2'd1,
      deq_min = 2'd2,
      replace = 2'd3   // overwrite the root and sift the new entry down
   } heap_op_t;

endpackage
